/* project.f */
source/rsp_bank_pkg.sv
source/slot_if.sv
source/slot_table.sv
source/id_queue_ctrl.sv
source/release_arbiter.sv
source/rsp_bank.sv
testbench/tb_clock_gen.sv
testbench/rsp_bank_assertions.sv
testbench/tb_rsp_bank.sv

/* testbench/tb_rsp_bank.sv */
/*
 * Random traffic through the response bank against a queue-based model.
 * Phases: dense release mask, sparse mask, long back-pressure, mixed,
 * then a drain with all slots enabled until the model is empty.
 */
`timescale 1ns/1ns
`default_nettype none

module tb_rsp_bank;

  localparam int NumCycles = 2000;
  localparam int PhaseLen  = 500;
  localparam int Drain     = 4;

  logic clk;
  logic rst_n;

  rsp_bank_pkg::axi_id_t              rsv_id;
  logic                               rsv_valid;
  logic                               rsv_ready;
  rsp_bank_pkg::bank_addr_t           rsv_addr;
  rsp_bank_pkg::wresp_t               in_data;
  logic                               in_valid;
  logic                               in_ready;
  logic [rsp_bank_pkg::TotCapa-1:0]   release_en;
  logic [rsp_bank_pkg::TotCapa-1:0]   released;
  rsp_bank_pkg::wresp_t               out_data;
  logic                               out_valid;
  logic                               out_ready;

  // Model: unreleased slots and filled payloads per identifier
  rsp_bank_pkg::bank_addr_t         addr_q [rsp_bank_pkg::NumIds][$];
  rsp_bank_pkg::content_t           pay_q  [rsp_bank_pkg::NumIds][$];
  logic [rsp_bank_pkg::TotCapa-1:0] busy;
  logic                             exp_valid;
  rsp_bank_pkg::wresp_t             exp_data;

  logic [31:0] rng;
  int          ready_hold;
  int          n_rsv;
  int          n_fill;
  int          n_out;

  tb_clock_gen u_clock_gen (
    .o_clk   (clk),
    .o_rst_n (rst_n)
  );

  rsp_bank u_dut (
    .clk_i             (clk),
    .rst_ni            (rst_n),
    .i_rsv_id          (rsv_id),
    .i_rsv_valid       (rsv_valid),
    .o_rsv_ready       (rsv_ready),
    .o_rsv_addr        (rsv_addr),
    .i_data            (in_data),
    .i_in_valid        (in_valid),
    .o_in_ready        (in_ready),
    .i_release_en      (release_en),
    .o_released_onehot (released),
    .o_data            (out_data),
    .o_out_valid       (out_valid),
    .i_out_ready       (out_ready)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Helpers and reference functions
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Lowest slot the model holds as unoccupied
  function automatic rsp_bank_pkg::bank_addr_t lowest_free(input logic [7:0] occ);
    for (int s = 0; s < rsp_bank_pkg::TotCapa; s++) begin
      if (!occ[s]) return rsp_bank_pkg::bank_addr_t'(s);
    end
    return '0;
  endfunction

  // Lowest id with a filled, enabled head, or -1
  function automatic int pick_release(input logic [7:0] mask);
    for (int i = 0; i < rsp_bank_pkg::NumIds; i++) begin
      if (pay_q[i].size() > 0 && mask[addr_q[i][0]]) return i;
    end
    return -1;
  endfunction

  function automatic int unfilled(input int id);
    return addr_q[id].size() - pay_q[id].size();
  endfunction

  function automatic logic model_empty();
    for (int i = 0; i < rsp_bank_pkg::NumIds; i++) begin
      if (addr_q[i].size() > 0) return 1'b0;
    end
    return !exp_valid;
  endfunction

  task automatic abort_run();
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation stopped on error");
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic compare_addr(input string name, input rsp_bank_pkg::bank_addr_t got,
                              input rsp_bank_pkg::bank_addr_t exp);
    if (got !== exp) begin
      $display("ERR %0t ns %s got %0d expected %0d", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic compare_resp(input string name, input rsp_bank_pkg::wresp_t got,
                              input rsp_bank_pkg::wresp_t exp);
    if (got !== exp) begin
      $display("ERR %0t ns %s got id %0d data %h expected id %0d data %h",
               $time, name, got.id, got.content, exp.id, exp.content);
      abort_run();
    end
  endtask

  task automatic compare_onehot(input string name,
                                input logic [rsp_bank_pkg::TotCapa-1:0] got,
                                input logic [rsp_bank_pkg::TotCapa-1:0] exp);
    if (got !== exp) begin
      $display("ERR %0t ns %s got %b expected %b", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic compare_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERR %0t ns %s got %b expected %b", $time, name, got, exp);
      abort_run();
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Checker, runs at the falling edge when all outputs are settled
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_and_update();
    logic                                can_load;
    int                                  sel;
    logic                                rsv_fire;
    logic                                exp_in_ready;
    rsp_bank_pkg::bank_addr_t            grant;
    logic [rsp_bank_pkg::TotCapa-1:0]    exp_onehot;

    compare_bit("o_out_valid", out_valid, exp_valid);
    if (exp_valid) compare_resp("o_data", out_data, exp_data);
    if (exp_valid && out_ready) n_out++;

    // Release only when the register is empty or drains at this edge
    can_load   = !exp_valid || out_ready;
    sel        = pick_release(release_en);
    exp_onehot = '0;
    if (can_load && sel >= 0) exp_onehot[addr_q[sel][0]] = 1'b1;
    compare_onehot("o_released_onehot", released, exp_onehot);

    compare_bit("o_rsv_ready", rsv_ready, busy != '1);
    rsv_fire = rsv_valid && (busy != '1);
    grant    = lowest_free(busy);
    if (rsv_fire) compare_addr("o_rsv_addr", rsv_addr, grant);

    exp_in_ready = in_valid && (unfilled(int'(in_data.id)) > 0);
    compare_bit("o_in_ready", in_ready, exp_in_ready);

    // Apply what the coming rising edge does
    if (can_load) begin
      exp_valid = (sel >= 0);
      if (sel >= 0) begin
        exp_data.id      = rsp_bank_pkg::axi_id_t'(sel);
        exp_data.content = pay_q[sel].pop_front();
        busy[addr_q[sel].pop_front()] = 1'b0;
      end
    end
    if (rsv_fire) begin
      busy[grant] = 1'b1;
      addr_q[rsv_id].push_back(grant);
      n_rsv++;
    end
    if (exp_in_ready) begin
      pay_q[in_data.id].push_back(in_data.content);
      n_fill++;
    end
  endtask

  // Protocol assertions of the bound checker stop the run as well
  always @(negedge clk) begin
    if (u_dut.u_assertions.fail_cnt != 0) begin
      $display("A protocol assertion on the DUT ports failed");
      abort_run();
    end else if (rst_n) begin
      check_and_update();
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  task automatic drive_cycle(input int phase);
    logic [31:0] r;
    logic [31:0] m;
    logic [31:0] b;
    int          id;

    rng = xorshift32(rng);
    r   = rng;
    rng = xorshift32(rng);
    m   = rng;
    rng = xorshift32(rng);
    b   = rng;

    rsv_valid <= (phase != Drain) && (r[1:0] != 2'b00);
    rsv_id    <= r[3:2];

    // Mostly aim at an id with a reserved, unfilled slot
    id = int'(r[17:16]);
    if (r[7:6] != 2'b00 || phase == Drain) begin
      for (int k = 0; k < rsp_bank_pkg::NumIds; k++) begin
        if (unfilled((int'(r[17:16]) + k) % rsp_bank_pkg::NumIds) > 0 &&
            unfilled(id) == 0) begin
          id = (int'(r[17:16]) + k) % rsp_bank_pkg::NumIds;
        end
      end
    end
    in_valid         <= (phase == Drain) ? (unfilled(id) > 0) : (r[4] | r[5]);
    in_data.id       <= rsp_bank_pkg::axi_id_t'(id);
    in_data.content  <= r[15:8];

    // Dense mask has about 7 of 8 bits set, sparse about 1 of 8
    if (phase == Drain) release_en <= '1;
    else if (phase == 1) release_en <= m[7:0] & m[15:8] & m[23:16];
    else release_en <= m[7:0] | m[15:8] | m[23:16];

    // Ready in bursts, long low stretches in phase 2
    if (phase == Drain) begin
      out_ready <= 1'b1;
    end else if (ready_hold == 0) begin
      out_ready  <= (phase == 2) ? b[0] : (b[2:0] != 3'b000);
      ready_hold = (phase == 2) ? 4 + int'(b[7:4]) : 1 + int'(b[6:4]);
    end else begin
      ready_hold--;
    end
  endtask

  initial begin
    rng        = 32'd54849;
    ready_hold = 0;
    n_rsv      = 0;
    n_fill     = 0;
    n_out      = 0;
    busy       = '0;
    exp_valid  = 1'b0;
    exp_data   = '0;
    rsv_id     = '0;
    rsv_valid  = 1'b0;
    in_data    = '0;
    in_valid   = 1'b0;
    release_en = '0;
    out_ready  = 1'b0;

    wait (rst_n === 1'b1);
    for (int c = 0; c < NumCycles; c++) begin
      @(posedge clk);
      drive_cycle(c / PhaseLen);
    end
    while (!model_empty()) begin
      @(posedge clk);
      drive_cycle(Drain);
    end
    repeat (4) @(posedge clk);

    if (n_out == 0 || n_out != n_fill || n_fill != n_rsv) begin
      $display("Response count mismatch, reserved %0d filled %0d output %0d",
               n_rsv, n_fill, n_out);
      abort_run();
    end else begin
      $display("Reserved %0d, filled %0d, output %0d", n_rsv, n_fill, n_out);
      $display("TEST RESULT: PASS");
      $finish;
    end
  end

  // Watchdog, ten times the nominal run length
  initial begin
    #(NumCycles * 40);
    $display("Watchdog expired before the run finished");
    abort_run();
  end

endmodule

`default_nettype wire

/* testbench/rsp_bank_assertions.sv */
/*
 * Protocol checks on the top-level ports of the response bank.
 * Bound into every rsp_bank instance.
 */
`timescale 1ns/1ns
`default_nettype none

module rsp_bank_assertions (
  input logic                             clk_i,
  input logic                             rst_ni,
  input logic                             i_in_valid,
  input logic                             i_in_ready,
  input logic                             i_out_valid,
  input logic                             i_out_ready,
  input rsp_bank_pkg::wresp_t             i_out_data,
  input logic [rsp_bank_pkg::TotCapa-1:0] i_released
);

  // Number of failed checks so far
  int unsigned fail_cnt = 0;

  // Held entry must not move while the sink stalls
  data_stable_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (i_out_valid && !i_out_ready) |=> (i_out_valid && $stable(i_out_data)))
    else begin
      $error("output data changed under back-pressure");
      fail_cnt++;
    end

  // At most one slot freed per cycle
  onehot_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
      $onehot0(i_released))
    else begin
      $error("released slot vector is not one-hot");
      fail_cnt++;
    end

  reset_valid_a: assert property (@(posedge clk_i) !rst_ni |-> !i_out_valid)
    else begin
      $error("output valid high during reset");
      fail_cnt++;
    end

  // Ready may only follow valid
  in_ready_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
      i_in_ready |-> i_in_valid)
    else begin
      $error("input ready without input valid");
      fail_cnt++;
    end

endmodule

bind rsp_bank rsp_bank_assertions u_assertions (
  .clk_i       (clk_i),
  .rst_ni      (rst_ni),
  .i_in_valid  (i_in_valid),
  .i_in_ready  (o_in_ready),
  .i_out_valid (o_out_valid),
  .i_out_ready (i_out_ready),
  .i_out_data  (o_data),
  .i_released  (o_released_onehot)
);

`default_nettype wire

/* testbench/tb_clock_gen.sv */
/*
 * Free-running 4 ns clock and an active-low reset held for 10 cycles.
 * Reset is released on a rising edge.
 */
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
  output logic o_clk,
  output logic o_rst_n
);

  // Half period of 2 ns
  initial begin
    o_clk = 1'b0;
    forever #2 o_clk = ~o_clk;
  end

  initial begin
    o_rst_n = 1'b0;
    repeat (10) @(posedge o_clk);
    o_rst_n <= 1'b1;
  end

endmodule

`default_nettype wire

/* source/rsp_bank.sv */
/*
 * Write-response bank with eight slots shared by four identifiers.
 * Responses leave in reservation order per identifier, only when the
 * release-enable bit of their slot is set.
 */
`timescale 1ns/1ns
`default_nettype none

module rsp_bank (
  input  logic                              clk_i,
  input  logic                              rst_ni,

  // Reservation
  input  rsp_bank_pkg::axi_id_t             i_rsv_id,
  input  logic                              i_rsv_valid,
  output logic                              o_rsv_ready,
  output rsp_bank_pkg::bank_addr_t          o_rsv_addr,

  // Responses from the memory controller
  input  rsp_bank_pkg::wresp_t              i_data,
  input  logic                              i_in_valid,
  output logic                              o_in_ready,

  // Release gating
  input  logic [rsp_bank_pkg::TotCapa-1:0]  i_release_en,
  output logic [rsp_bank_pkg::TotCapa-1:0]  o_released_onehot,

  // Responses to the requester
  output rsp_bank_pkg::wresp_t              o_data,
  output logic                              o_out_valid,
  input  logic                              i_out_ready
);

  slot_if u_slot_if ();

  // Granted slot is the table's lowest free slot
  assign o_rsv_addr = u_slot_if.free_addr;

  slot_table u_slot_table (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .slots  (u_slot_if.tbl)
  );

  id_queue_ctrl u_id_queue_ctrl (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .i_rsv_valid  (i_rsv_valid),
    .i_rsv_id     (i_rsv_id),
    .i_in_valid   (i_in_valid),
    .i_in_id      (i_data.id),
    .i_in_content (i_data.content),
    .o_rsv_ready  (o_rsv_ready),
    .o_in_ready   (o_in_ready),
    .slots        (u_slot_if.queue)
  );

  release_arbiter u_release_arbiter (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .i_release_en      (i_release_en),
    .i_out_ready       (i_out_ready),
    .o_out_valid       (o_out_valid),
    .o_out_data        (o_data),
    .o_released_onehot (o_released_onehot),
    .slots             (u_slot_if.arbiter)
  );

endmodule

`default_nettype wire

/* source/release_arbiter.sv */
/*
 * Picks the lowest identifier whose head slot is filled and enabled, and
 * loads it into a one-entry output register. The release pulse is
 * combinational and falls in the cycle before the register takes the entry.
 */
`timescale 1ns/1ns
`default_nettype none

module release_arbiter (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic [rsp_bank_pkg::TotCapa-1:0]  i_release_en,
  input  logic                              i_out_ready,
  output logic                              o_out_valid,
  output rsp_bank_pkg::wresp_t              o_out_data,
  output logic [rsp_bank_pkg::TotCapa-1:0]  o_released_onehot,
  slot_if.arbiter                           slots
);

  logic [rsp_bank_pkg::NumIds-1:0] cand;
  logic                            any_cand;
  rsp_bank_pkg::axi_id_t           sel_id;
  logic                            can_load;
  logic                            valid_q;
  rsp_bank_pkg::wresp_t            data_q;

  ////////////////////////////////////////////////////////////////////////////
  // Candidate selection
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    for (int i = 0; i < rsp_bank_pkg::NumIds; i++) begin
      cand[i] = slots.head_filled[i] && i_release_en[slots.head_addr_id[i]];
    end
  end

  assign any_cand = |cand;

  // Lowest identifier wins
  always_comb begin
    sel_id = '0;
    for (int i = rsp_bank_pkg::NumIds - 1; i >= 0; i--) begin
      if (cand[i]) begin
        sel_id = rsp_bank_pkg::axi_id_t'(i);
      end
    end
  end

  // Register empty or drained this cycle
  assign can_load = !valid_q || i_out_ready;

  assign slots.release_en   = can_load && any_cand;
  assign slots.release_id   = sel_id;
  assign slots.release_addr = slots.head_addr_id[sel_id];

  always_comb begin
    for (int a = 0; a < rsp_bank_pkg::TotCapa; a++) begin
      o_released_onehot[a] =
          slots.release_en && (slots.release_addr == rsp_bank_pkg::bank_addr_t'(a));
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Output register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (can_load) begin
      valid_q <= any_cand;
    end
  end

  // Held under back-pressure since release_en is low then
  always_ff @(posedge clk_i) begin
    if (slots.release_en) begin
      data_q.id      <= sel_id;
      data_q.content <= slots.release_content;
    end
  end

  assign o_out_valid = valid_q;
  assign o_out_data  = data_q;

endmodule

`default_nettype wire

/* source/id_queue_ctrl.sv */
/*
 * Per-identifier linked-list pointers and counters.
 * A fill always goes to the oldest reserved slot of its identifier,
 * so fill order equals reservation order within one identifier.
 */
`timescale 1ns/1ns
`default_nettype none

module id_queue_ctrl (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   i_rsv_valid,
  input  rsp_bank_pkg::axi_id_t  i_rsv_id,
  input  logic                   i_in_valid,
  input  rsp_bank_pkg::axi_id_t  i_in_id,
  input  rsp_bank_pkg::content_t i_in_content,
  output logic                   o_rsv_ready,
  output logic                   o_in_ready,
  slot_if.queue                  slots
);

  typedef logic [rsp_bank_pkg::CntWidth-1:0] cnt_t;

  // Head is the oldest unreleased slot, mid the next to fill, tail the newest
  rsp_bank_pkg::bank_addr_t head_q [rsp_bank_pkg::NumIds];
  rsp_bank_pkg::bank_addr_t head_d [rsp_bank_pkg::NumIds];
  rsp_bank_pkg::bank_addr_t mid_q  [rsp_bank_pkg::NumIds];
  rsp_bank_pkg::bank_addr_t mid_d  [rsp_bank_pkg::NumIds];
  rsp_bank_pkg::bank_addr_t tail_q [rsp_bank_pkg::NumIds];
  rsp_bank_pkg::bank_addr_t tail_d [rsp_bank_pkg::NumIds];

  // Reserved but unfilled, and filled but unreleased
  cnt_t rsv_cnt_q  [rsp_bank_pkg::NumIds];
  cnt_t rsv_cnt_d  [rsp_bank_pkg::NumIds];
  cnt_t fill_cnt_q [rsp_bank_pkg::NumIds];
  cnt_t fill_cnt_d [rsp_bank_pkg::NumIds];

  logic [rsp_bank_pkg::NumIds-1:0] rsv_hit;
  logic [rsp_bank_pkg::NumIds-1:0] fill_hit;
  logic [rsp_bank_pkg::NumIds-1:0] rel_hit;
  // Queue holds nothing once this cycle's release is done
  logic [rsp_bank_pkg::NumIds-1:0] q_empty;

  ////////////////////////////////////////////////////////////////////////////
  // Handshakes and table requests
  ////////////////////////////////////////////////////////////////////////////

  assign o_rsv_ready = slots.any_free;
  // Ready follows valid, as AXI allows
  assign o_in_ready  = i_in_valid && (rsv_cnt_q[i_in_id] != '0);

  assign slots.alloc_en     = i_rsv_valid && slots.any_free;
  assign slots.alloc_id     = i_rsv_id;
  assign slots.link_en      = slots.alloc_en && !q_empty[i_rsv_id];
  assign slots.link_from    = tail_q[i_rsv_id];
  assign slots.fill_en      = o_in_ready;
  assign slots.fill_addr    = mid_q[i_in_id];
  assign slots.fill_content = i_in_content;
  assign slots.mid_addr     = mid_q[i_in_id];
  assign slots.head_addr    = head_q[slots.release_id];
  assign slots.head_addr_id = head_q;

  ////////////////////////////////////////////////////////////////////////////
  // Pointer and counter update
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    for (int i = 0; i < rsp_bank_pkg::NumIds; i++) begin
      rsv_hit[i]  = slots.alloc_en && (i_rsv_id == rsp_bank_pkg::axi_id_t'(i));
      fill_hit[i] = slots.fill_en && (i_in_id == rsp_bank_pkg::axi_id_t'(i));
      rel_hit[i]  = slots.release_en && (slots.release_id == rsp_bank_pkg::axi_id_t'(i));
      q_empty[i]  = (rsv_cnt_q[i] == '0) && (fill_cnt_q[i] == cnt_t'(rel_hit[i]));

      rsv_cnt_d[i]  = rsv_cnt_q[i] + cnt_t'(rsv_hit[i]) - cnt_t'(fill_hit[i]);
      fill_cnt_d[i] = fill_cnt_q[i] + cnt_t'(fill_hit[i]) - cnt_t'(rel_hit[i]);

      tail_d[i] = rsv_hit[i] ? slots.free_addr : tail_q[i];

      // New queue starts at the granted slot, else follow the link
      if (rsv_hit[i] && q_empty[i]) begin
        head_d[i] = slots.free_addr;
      end else if (rel_hit[i] && !q_empty[i]) begin
        head_d[i] = slots.head_next;
      end else begin
        head_d[i] = head_q[i];
      end

      // Mid jumps to the new slot when nothing else waits for a fill
      if (rsv_hit[i] && (rsv_cnt_q[i] == cnt_t'(fill_hit[i]))) begin
        mid_d[i] = slots.free_addr;
      end else if (fill_hit[i] && (rsv_cnt_q[i] != cnt_t'(1))) begin
        mid_d[i] = slots.mid_next;
      end else begin
        mid_d[i] = mid_q[i];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      head_q     <= '{default: '0};
      mid_q      <= '{default: '0};
      tail_q     <= '{default: '0};
      rsv_cnt_q  <= '{default: '0};
      fill_cnt_q <= '{default: '0};
    end else begin
      head_q     <= head_d;
      mid_q      <= mid_d;
      tail_q     <= tail_d;
      rsv_cnt_q  <= rsv_cnt_d;
      fill_cnt_q <= fill_cnt_d;
    end
  end

endmodule

`default_nettype wire

/* source/slot_table.sv */
/*
 * Slot storage: state, owner, next pointer and payload of every slot.
 * All arrays are flops read combinationally. The queue control keeps
 * alloc, fill and release on distinct slots in any one cycle.
 */
`timescale 1ns/1ns
`default_nettype none

module slot_table (
  input logic clk_i,
  input logic rst_ni,
  slot_if.tbl slots
);

  rsp_bank_pkg::slot_state_e state_q [rsp_bank_pkg::TotCapa];
  rsp_bank_pkg::axi_id_t     owner_q [rsp_bank_pkg::TotCapa];
  rsp_bank_pkg::bank_addr_t  next_q  [rsp_bank_pkg::TotCapa];
  rsp_bank_pkg::content_t    msg_q   [rsp_bank_pkg::TotCapa];

  ////////////////////////////////////////////////////////////////////////////
  // Lowest free slot
  ////////////////////////////////////////////////////////////////////////////

  // Walk down so the lowest free index is the last one kept
  always_comb begin
    slots.free_addr = '0;
    slots.any_free  = 1'b0;
    for (int s = rsp_bank_pkg::TotCapa - 1; s >= 0; s--) begin
      if (state_q[s] == rsp_bank_pkg::SLOT_FREE) begin
        slots.free_addr = rsp_bank_pkg::bank_addr_t'(s);
        slots.any_free  = 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Slot state
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= '{default: rsp_bank_pkg::SLOT_FREE};
    end else begin
      if (slots.alloc_en) begin
        state_q[slots.free_addr] <= rsp_bank_pkg::SLOT_RESERVED;
      end
      if (slots.fill_en) begin
        state_q[slots.fill_addr] <= rsp_bank_pkg::SLOT_FILLED;
      end
      // Released slot is free again from the next cycle
      if (slots.release_en) begin
        state_q[slots.release_addr] <= rsp_bank_pkg::SLOT_FREE;
      end
    end
  end

  // Owner, links and payload
  always_ff @(posedge clk_i) begin
    if (slots.alloc_en) begin
      owner_q[slots.free_addr] <= slots.alloc_id;
    end
    // Old tail points to the slot granted in the same cycle
    if (slots.link_en) begin
      next_q[slots.link_from] <= slots.free_addr;
    end
    if (slots.fill_en) begin
      msg_q[slots.fill_addr] <= slots.fill_content;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Lookups
  ////////////////////////////////////////////////////////////////////////////

  assign slots.mid_next        = next_q[slots.mid_addr];
  assign slots.head_next       = next_q[slots.head_addr];
  assign slots.release_content = msg_q[slots.release_addr];

  // A head pointer of an empty queue may be stale, the owner check masks it
  always_comb begin
    for (int i = 0; i < rsp_bank_pkg::NumIds; i++) begin
      slots.head_filled[i] =
          (state_q[slots.head_addr_id[i]] == rsp_bank_pkg::SLOT_FILLED) &&
          (owner_q[slots.head_addr_id[i]] == rsp_bank_pkg::axi_id_t'(i));
    end
  end

endmodule

`default_nettype wire

/* source/slot_if.sv */
/*
 * Internal bus between the queue control, the slot table and the release
 * arbiter. At most one alloc, one fill and one release per cycle.
 */
`timescale 1ns/1ns
`default_nettype none

interface slot_if;

  // Lowest free slot, and whether one exists
  rsp_bank_pkg::bank_addr_t free_addr;
  logic                     any_free;

  // Reservation, with the new slot linked behind link_from
  logic                     alloc_en;
  rsp_bank_pkg::axi_id_t    alloc_id;
  logic                     link_en;
  rsp_bank_pkg::bank_addr_t link_from;

  // Fill of a reserved slot
  logic                     fill_en;
  rsp_bank_pkg::bank_addr_t fill_addr;
  rsp_bank_pkg::content_t   fill_content;

  // Next-pointer lookups
  rsp_bank_pkg::bank_addr_t mid_addr;
  rsp_bank_pkg::bank_addr_t mid_next;
  rsp_bank_pkg::bank_addr_t head_addr;
  rsp_bank_pkg::bank_addr_t head_next;

  // Release of one head slot
  logic                     release_en;
  rsp_bank_pkg::axi_id_t    release_id;
  rsp_bank_pkg::bank_addr_t release_addr;
  rsp_bank_pkg::content_t   release_content;

  // Head status per identifier
  logic [rsp_bank_pkg::NumIds-1:0] head_filled;
  rsp_bank_pkg::bank_addr_t        head_addr_id [rsp_bank_pkg::NumIds];

  modport queue (
    input  free_addr, any_free, mid_next, head_next, release_en, release_id,
    output alloc_en, alloc_id, link_en, link_from, fill_en, fill_addr, fill_content,
    output mid_addr, head_addr, head_addr_id
  );

  modport tbl (
    input  alloc_en, alloc_id, link_en, link_from, fill_en, fill_addr, fill_content,
    input  mid_addr, head_addr, release_en, release_addr, head_addr_id,
    output free_addr, any_free, mid_next, head_next, head_filled, release_content
  );

  modport arbiter (
    input  head_filled, head_addr_id, release_content,
    output release_en, release_id, release_addr
  );

endinterface

`default_nettype wire

/* source/rsp_bank_pkg.sv */
/*
 * Shared sizes and types of the write-response bank.
 * TotCapa must be a power of two that fits in BankAddrWidth bits, and
 * CntWidth must be wide enough to count up to TotCapa.
 */
`default_nettype none

package rsp_bank_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////////////////////////////////////////

  localparam int NumIds        = 4;
  localparam int IdWidth       = 2;
  localparam int TotCapa       = 8;
  localparam int BankAddrWidth = 3;
  localparam int ContentWidth  = 8;
  // One bit more than the address, so a full bank still fits
  localparam int CntWidth      = 4;

  ////////////////////////////////////////////////////////////////////////////
  // Types
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [BankAddrWidth-1:0] bank_addr_t;
  typedef logic [IdWidth-1:0]       axi_id_t;
  typedef logic [ContentWidth-1:0]  content_t;

  // Write response without its handshake, id in the upper bits
  typedef struct packed {
    axi_id_t  id;
    content_t content;
  } wresp_t;

  // Life cycle of one slot
  typedef enum logic [1:0] {
    SLOT_FREE     = 2'd0,
    SLOT_RESERVED = 2'd1,
    SLOT_FILLED   = 2'd2
  } slot_state_e;

endpackage

`default_nettype wire
